/* verilog/pid_pkg.sv */
package pid_pkg;

    // ----------------------------------------------------------
    // Host write bus widths
    // ----------------------------------------------------------
    localparam int W_WR_ADDR = 4;
    localparam int W_WR_CHAN = 8;
    localparam int W_WR_DATA = 32;

    // Configuration register map
    typedef enum logic [W_WR_ADDR-1:0] {
        PID_SETPOINT  = 4'h0,
        PID_P_COEF    = 4'h1,
        PID_I_COEF    = 4'h2,
        PID_D_COEF    = 4'h3,
        PID_INV_ERROR = 4'h4,
        // Bit 0 requests a history flush
        PID_CLR_RQST  = 4'h5
    } pid_reg_e;

    // ----------------------------------------------------------
    // Datapath width helpers
    // ----------------------------------------------------------
    // k1 = P+I+D and k2 = -P-2D need two extra bits
    function automatic int pid_kcoef_width(input int w_coef);
        return w_coef + 2;
    endfunction

    // Product width plus two bits for the three-term sum
    function automatic int pid_delta_width(input int w_din, input int w_coef);
        return (w_coef + 2) + (w_din + 1) + 2;
    endfunction

endpackage

/* verilog/pid_param_if.sv */
interface pid_param_if #(
    parameter int N_CHAN = 8,
    parameter int W_DIN  = 18,
    parameter int W_COEF = 16,
    localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
);

    // Channel being fetched by the pipeline
    logic [W_CHAN-1:0]        rd_chan;

    // Configuration of rd_chan, returned without a clock
    logic signed [W_DIN-1:0]  setpoint;
    logic signed [W_COEF-1:0] p_coef;
    logic signed [W_COEF-1:0] i_coef;
    logic signed [W_COEF-1:0] d_coef;
    logic                     inv_error;

    // One-cycle clear pulses, one bit per channel
    logic [N_CHAN-1:0]        clr_mask;

    modport filter (
        output rd_chan,
        input  setpoint, p_coef, i_coef, d_coef, inv_error, clr_mask
    );

    modport bank (
        input  rd_chan,
        output setpoint, p_coef, i_coef, d_coef, inv_error, clr_mask
    );

endinterface

/* verilog/pid_coef_bank.sv */
module pid_coef_bank import pid_pkg::*; #(
    parameter int N_CHAN = 8,
    parameter int W_DIN  = 18,
    parameter int W_COEF = 16,
    localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
    input  logic                 clk_in,
    input  logic                 reset,
    input  logic                 wr_en,
    input  pid_reg_e             wr_addr,
    input  logic [W_WR_CHAN-1:0] wr_chan,
    input  logic [W_WR_DATA-1:0] wr_data,
    pid_param_if.bank            prm
);

    // ----------------------------------------------------------
    // Write decode
    // ----------------------------------------------------------
    logic              wr_ok;
    logic [W_CHAN-1:0] wr_idx;

    // Out of range channels dropped here
    assign wr_ok  = wr_en && (wr_chan < N_CHAN);
    assign wr_idx = W_CHAN'(wr_chan);

    // ----------------------------------------------------------
    // Per-channel configuration
    // ----------------------------------------------------------
    logic signed [W_DIN-1:0]  setpoint_mem [N_CHAN];
    logic signed [W_COEF-1:0] p_coef_mem   [N_CHAN];
    logic signed [W_COEF-1:0] i_coef_mem   [N_CHAN];
    logic signed [W_COEF-1:0] d_coef_mem   [N_CHAN];
    logic [N_CHAN-1:0]        inv_error_mem;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < N_CHAN; i++) begin
                setpoint_mem[i] <= '0;
                p_coef_mem[i]   <= '0;
                i_coef_mem[i]   <= '0;
                d_coef_mem[i]   <= '0;
            end
            inv_error_mem <= '0;
        end else if (wr_ok) begin
            // Data truncated to field width, upper bits ignored
            case (wr_addr)
                PID_SETPOINT:  setpoint_mem[wr_idx]  <= signed'(wr_data[W_DIN-1:0]);
                PID_P_COEF:    p_coef_mem[wr_idx]    <= signed'(wr_data[W_COEF-1:0]);
                PID_I_COEF:    i_coef_mem[wr_idx]    <= signed'(wr_data[W_COEF-1:0]);
                PID_D_COEF:    d_coef_mem[wr_idx]    <= signed'(wr_data[W_COEF-1:0]);
                PID_INV_ERROR: inv_error_mem[wr_idx] <= wr_data[0];
                // Clear request and unknown addresses
                default: ;
            endcase
        end
    end

    // Combinational read port for the fetch stage
    assign prm.setpoint  = setpoint_mem[prm.rd_chan];
    assign prm.p_coef    = p_coef_mem[prm.rd_chan];
    assign prm.i_coef    = i_coef_mem[prm.rd_chan];
    assign prm.d_coef    = d_coef_mem[prm.rd_chan];
    assign prm.inv_error = inv_error_mem[prm.rd_chan];

    // ----------------------------------------------------------
    // Clear request register
    // ----------------------------------------------------------
    logic [N_CHAN-1:0] clr_set;
    logic [N_CHAN-1:0] clr_mask_q;

    always_comb begin
        clr_set = '0;
        if (wr_ok && (wr_addr == PID_CLR_RQST) && wr_data[0]) begin
            clr_set[wr_idx] = 1'b1;
        end
    end

    // One-cycle pulse per clear write
    always_ff @(posedge clk_in) begin
        if (reset) begin
            clr_mask_q <= '0;
        end else begin
            clr_mask_q <= clr_set;
        end
    end

    assign prm.clr_mask = clr_mask_q;

    // Filter relies on a single-cycle flush per request
    a_clr_single_cycle: assert property (
        @(posedge clk_in) disable iff (reset)
        (clr_mask_q & $past(clr_mask_q)) == '0
    );

endmodule

/* verilog/pid_filter.sv */
module pid_filter import pid_pkg::*; #(
    parameter int N_CHAN = 8,
    parameter int W_DIN  = 18,
    parameter int W_COEF = 16,
    parameter int W_DOUT = 40,
    localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
    input  logic                     clk_in,
    input  logic                     reset,
    input  logic                     dv_in,
    input  logic [W_CHAN-1:0]        chan_in,
    input  logic signed [W_DIN-1:0]  data_in,
    pid_param_if.filter              prm,
    output logic                     dv_out,
    output logic [W_CHAN-1:0]        chan_out,
    output logic signed [W_DOUT-1:0] data_out
);

    // ----------------------------------------------------------
    // Datapath widths
    // ----------------------------------------------------------
    localparam int W_ERR   = W_DIN + 1;
    localparam int W_K     = pid_kcoef_width(W_COEF);
    localparam int W_PROD  = W_K + W_ERR;
    localparam int W_DELTA = pid_delta_width(W_DIN, W_COEF);
    // One guard bit over the wider addend
    localparam int W_SUM   = ((W_DOUT > W_DELTA) ? W_DOUT : W_DELTA) + 1;

    localparam logic signed [W_DOUT-1:0] MAX_DOUT = {1'b0, {(W_DOUT-1){1'b1}}};
    localparam logic signed [W_DOUT-1:0] MIN_DOUT = {1'b1, {(W_DOUT-1){1'b0}}};

    // Per-channel history
    logic signed [W_ERR-1:0]  e1_mem  [N_CHAN];
    logic signed [W_ERR-1:0]  e2_mem  [N_CHAN];
    logic signed [W_DOUT-1:0] out_mem [N_CHAN];

    // Stage valid and channel tags
    logic              dv_p1, dv_p2, dv_p3, dv_p4, dv_p5, dv_p6;
    logic [W_CHAN-1:0] chan_p1, chan_p2, chan_p3, chan_p4, chan_p5, chan_p6;

    // Flush per stage, keyed on the channel entering it
    logic flush_p1, flush_p2, flush_p3, flush_p4, flush_p5, flush_p6;

    assign flush_p1 = reset || prm.clr_mask[chan_in];
    assign flush_p2 = reset || prm.clr_mask[chan_p1];
    assign flush_p3 = reset || prm.clr_mask[chan_p2];
    assign flush_p4 = reset || prm.clr_mask[chan_p3];
    assign flush_p5 = reset || prm.clr_mask[chan_p4];
    assign flush_p6 = reset || prm.clr_mask[chan_p5];

    // Valid bits move unless the stage is flushed
    always_ff @(posedge clk_in) begin
        dv_p1 <= flush_p1 ? 1'b0 : dv_in;
        dv_p2 <= flush_p2 ? 1'b0 : dv_p1;
        dv_p3 <= flush_p3 ? 1'b0 : dv_p2;
        dv_p4 <= flush_p4 ? 1'b0 : dv_p3;
        dv_p5 <= flush_p5 ? 1'b0 : dv_p4;
        dv_p6 <= flush_p6 ? 1'b0 : dv_p5;
    end

    always_ff @(posedge clk_in) begin
        chan_p1 <= chan_in;
        chan_p2 <= chan_p1;
        chan_p3 <= chan_p2;
        chan_p4 <= chan_p3;
        chan_p5 <= chan_p4;
        chan_p6 <= chan_p5;
    end

    // ----------------------------------------------------------
    // Stage 1 fetch configuration
    // ----------------------------------------------------------
    logic signed [W_DIN-1:0]  din_p1;
    logic signed [W_DIN-1:0]  setpoint_p1;
    logic signed [W_COEF-1:0] p_coef_p1, i_coef_p1, d_coef_p1;
    logic                     inv_p1;

    assign prm.rd_chan = chan_in;

    always_ff @(posedge clk_in) begin
        din_p1      <= data_in;
        setpoint_p1 <= prm.setpoint;
        p_coef_p1   <= prm.p_coef;
        i_coef_p1   <= prm.i_coef;
        d_coef_p1   <= prm.d_coef;
        inv_p1      <= prm.inv_error;
    end

    // ----------------------------------------------------------
    // Stage 2 error, k-coefficients, history read
    // ----------------------------------------------------------
    logic signed [W_ERR-1:0] err_raw;
    logic signed [W_ERR-1:0] err_p2, e1_p2, e2_p2;
    logic signed [W_K-1:0]   k1_p2, k2_p2, k3_p2;

    // One extra bit so the difference cannot wrap
    assign err_raw = setpoint_p1 - din_p1;

    always_ff @(posedge clk_in) begin
        // Bitwise invert gives -e-1
        err_p2 <= inv_p1 ? ~err_raw : err_raw;
        k1_p2  <= p_coef_p1 + i_coef_p1 + d_coef_p1;
        k2_p2  <= -p_coef_p1 - (d_coef_p1 <<< 1);
        k3_p2  <= d_coef_p1;
        e1_p2  <= e1_mem[chan_p1];
        e2_p2  <= e2_mem[chan_p1];
    end

    // ----------------------------------------------------------
    // Stage 3 products and error writeback
    // ----------------------------------------------------------
    logic signed [W_PROD-1:0] prod1_p3, prod2_p3, prod3_p3;

    always_ff @(posedge clk_in) begin
        prod1_p3 <= k1_p2 * err_p2;
        prod2_p3 <= k2_p2 * e1_p2;
        prod3_p3 <= k3_p2 * e2_p2;
    end

    // Zeroing wins over a writeback in the same cycle
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < N_CHAN; i++) begin
            if (reset || prm.clr_mask[i]) begin
                e1_mem[i] <= '0;
                e2_mem[i] <= '0;
            end else if (dv_p2 && (chan_p2 == i)) begin
                // Shift history by one sample
                e1_mem[i] <= err_p2;
                e2_mem[i] <= e1_p2;
            end
        end
    end

    // ----------------------------------------------------------
    // Stage 4 delta sum, previous output read
    // ----------------------------------------------------------
    logic signed [W_DELTA-1:0] delta_p4;
    logic signed [W_DOUT-1:0]  out_prev_p4;

    always_ff @(posedge clk_in) begin
        delta_p4    <= prod1_p3 + prod2_p3 + prod3_p3;
        out_prev_p4 <= out_mem[chan_p3];
    end

    // ----------------------------------------------------------
    // Stage 5 accumulate and saturate
    // ----------------------------------------------------------
    logic signed [W_SUM-1:0]  sum_s5;
    logic signed [W_DOUT-1:0] sat_s5;
    logic signed [W_DOUT-1:0] dout_p5;

    always_comb begin
        sum_s5 = out_prev_p4 + delta_p4;
        // Clamp to the signed output range
        if (sum_s5 > MAX_DOUT) begin
            sat_s5 = MAX_DOUT;
        end else if (sum_s5 < MIN_DOUT) begin
            sat_s5 = MIN_DOUT;
        end else begin
            sat_s5 = sum_s5[W_DOUT-1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        dout_p5 <= sat_s5;
    end

    // ----------------------------------------------------------
    // Stage 6 output writeback and result register
    // ----------------------------------------------------------
    logic signed [W_DOUT-1:0] dout_p6;

    always_ff @(posedge clk_in) begin
        for (int i = 0; i < N_CHAN; i++) begin
            if (reset || prm.clr_mask[i]) begin
                out_mem[i] <= '0;
            end else if (dv_p5 && (chan_p5 == i)) begin
                out_mem[i] <= dout_p5;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        dout_p6 <= dout_p5;
    end

    assign dv_out   = dv_p6;
    assign chan_out = chan_p6;
    assign data_out = dout_p6;

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    a_chan_out_range: assert property (
        @(posedge clk_in) disable iff (reset)
        dv_out |-> (chan_out < N_CHAN)
    );

    // No forwarding, so a channel must have left stage 5 first
    a_no_hazard: assert property (
        @(posedge clk_in) disable iff (reset)
        dv_in |-> !((dv_p1 && (chan_p1 == chan_in)) ||
                    (dv_p2 && (chan_p2 == chan_in)) ||
                    (dv_p3 && (chan_p3 == chan_in)) ||
                    (dv_p4 && (chan_p4 == chan_in)) ||
                    (dv_p5 && (chan_p5 == chan_in)))
    );

endmodule

/* verilog/pid_ctrl_top.sv */
module pid_ctrl_top import pid_pkg::*; #(
    parameter int N_CHAN = 8,
    parameter int W_DIN  = 18,
    parameter int W_COEF = 16,
    parameter int W_DOUT = 40,
    localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1
) (
    input  logic                     clk_in,
    input  logic                     reset,

    // Configuration writes
    input  logic                     wr_en,
    input  logic [W_WR_ADDR-1:0]     wr_addr,
    input  logic [W_WR_CHAN-1:0]     wr_chan,
    input  logic [W_WR_DATA-1:0]     wr_data,

    // Sample stream in
    input  logic                     dv_in,
    input  logic [W_CHAN-1:0]        chan_in,
    input  logic signed [W_DIN-1:0]  data_in,

    // Result stream out
    output logic                     dv_out,
    output logic [W_CHAN-1:0]        chan_out,
    output logic signed [W_DOUT-1:0] data_out
);

    // Bank to filter configuration path
    pid_param_if #(
        .N_CHAN (N_CHAN),
        .W_DIN  (W_DIN),
        .W_COEF (W_COEF)
    ) prm_if ();

    // ----------------------------------------------------------
    // Configuration bank
    // ----------------------------------------------------------
    pid_coef_bank #(
        .N_CHAN (N_CHAN),
        .W_DIN  (W_DIN),
        .W_COEF (W_COEF)
    ) u_bank (
        .clk_in  (clk_in),
        .reset   (reset),
        .wr_en   (wr_en),
        // Unknown codes fall through the bank decode
        .wr_addr (pid_reg_e'(wr_addr)),
        .wr_chan (wr_chan),
        .wr_data (wr_data),
        .prm     (prm_if.bank)
    );

    // ----------------------------------------------------------
    // PID pipeline
    // ----------------------------------------------------------
    pid_filter #(
        .N_CHAN (N_CHAN),
        .W_DIN  (W_DIN),
        .W_COEF (W_COEF),
        .W_DOUT (W_DOUT)
    ) u_filter (
        .clk_in   (clk_in),
        .reset    (reset),
        .dv_in    (dv_in),
        .chan_in  (chan_in),
        .data_in  (data_in),
        .prm      (prm_if.filter),
        .dv_out   (dv_out),
        .chan_out (chan_out),
        .data_out (data_out)
    );

endmodule

/* verification/pid_model.svh */
`ifndef PID_MODEL_SVH
`define PID_MODEL_SVH

// ----------------------------------------------------------
// Reference state per channel
// ----------------------------------------------------------
localparam longint DOUT_MAX = (longint'(1) <<< (W_DOUT - 1)) - 1;
localparam longint DOUT_MIN = -(longint'(1) <<< (W_DOUT - 1));

longint cfg_setpoint [N_CHAN];
longint cfg_p        [N_CHAN];
longint cfg_i        [N_CHAN];
longint cfg_d        [N_CHAN];
bit     cfg_inv      [N_CHAN];

// Error and output history
longint hist_e1  [N_CHAN];
longint hist_e2  [N_CHAN];
longint hist_out [N_CHAN];

// Low bits of a write word taken as a signed field
function automatic longint sign_extend(input longint value, input int width);
    return (value <<< (64 - width)) >>> (64 - width);
endfunction

function automatic void zero_all_state();
    for (int i = 0; i < N_CHAN; i++) begin
        cfg_setpoint[i] = 0;
        cfg_p[i]        = 0;
        cfg_i[i]        = 0;
        cfg_d[i]        = 0;
        cfg_inv[i]      = 1'b0;
        hist_e1[i]      = 0;
        hist_e2[i]      = 0;
        hist_out[i]     = 0;
    end
endfunction

// Register map as seen from the host
function automatic void apply_cfg_write(input logic [W_WR_ADDR-1:0] addr,
                                        input logic [W_WR_CHAN-1:0] chan,
                                        input logic [W_WR_DATA-1:0] data);
    int ch;
    ch = chan;
    // Channels past the last one are dropped
    if (ch < N_CHAN) begin
        case (addr)
            PID_SETPOINT:  cfg_setpoint[ch] = sign_extend(longint'(data), W_DIN);
            PID_P_COEF:    cfg_p[ch] = sign_extend(longint'(data), W_COEF);
            PID_I_COEF:    cfg_i[ch] = sign_extend(longint'(data), W_COEF);
            PID_D_COEF:    cfg_d[ch] = sign_extend(longint'(data), W_COEF);
            PID_INV_ERROR: cfg_inv[ch] = data[0];
            PID_CLR_RQST: begin
                if (data[0]) begin
                    hist_e1[ch]  = 0;
                    hist_e2[ch]  = 0;
                    hist_out[ch] = 0;
                end
            end
            default: ;
        endcase
    end
endfunction

// Velocity form, one step
function automatic longint predict_output(input int ch, input longint din);
    longint err;
    longint k1;
    longint k2;
    longint k3;
    longint sum;
    err = cfg_setpoint[ch] - din;
    // Complemented error is -e-1
    if (cfg_inv[ch]) begin
        err = -err - 1;
    end
    k1  = cfg_p[ch] + cfg_i[ch] + cfg_d[ch];
    k2  = -cfg_p[ch] - 2 * cfg_d[ch];
    k3  = cfg_d[ch];
    sum = hist_out[ch] + k1 * err + k2 * hist_e1[ch] + k3 * hist_e2[ch];
    if (sum > DOUT_MAX) begin
        sum = DOUT_MAX;
    end else if (sum < DOUT_MIN) begin
        sum = DOUT_MIN;
    end
    hist_e2[ch]  = hist_e1[ch];
    hist_e1[ch]  = err;
    hist_out[ch] = sum;
    return sum;
endfunction

`endif

/* verification/pid_tb.sv */
module pid_tb import pid_pkg::*; ();

    localparam int N_CHAN = 8;
    localparam int W_DIN  = 18;
    localparam int W_COEF = 16;
    localparam int W_DOUT = 40;
    localparam int W_CHAN = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

    // Samples per section
    localparam int N_SINGLE  = 24;
    localparam int N_MIX     = 200;
    localparam int N_INV     = 24;
    localparam int N_SAT_UP  = 90;
    localparam int N_SAT_DN  = 150;
    localparam int N_CLR     = 48;
    localparam int N_SAMPLES = N_CHAN + N_SINGLE + N_MIX + N_INV + N_SAT_UP + N_SAT_DN + N_CLR;

    logic                     clk_in;
    logic                     reset;
    logic                     wr_en;
    logic [W_WR_ADDR-1:0]     wr_addr;
    logic [W_WR_CHAN-1:0]     wr_chan;
    logic [W_WR_DATA-1:0]     wr_data;
    logic                     dv_in;
    logic [W_CHAN-1:0]        chan_in;
    logic signed [W_DIN-1:0]  data_in;
    logic                     dv_out;
    logic [W_CHAN-1:0]        chan_out;
    logic signed [W_DOUT-1:0] data_out;

    typedef struct {
        logic [W_CHAN-1:0]        chan;
        logic signed [W_DOUT-1:0] data;
    } result_t;

    result_t exp_q [$];
    integer  seed = 32'hf8f4;
    int      cyc = 0;
    int      last_issue [N_CHAN];

    `include "pid_model.svh"

    pid_ctrl_top #(
        .N_CHAN (N_CHAN),
        .W_DIN  (W_DIN),
        .W_COEF (W_COEF),
        .W_DOUT (W_DOUT)
    ) u_pid_ctrl_top (
        .clk_in (clk_in), .reset (reset),
        .wr_en (wr_en), .wr_addr (wr_addr), .wr_chan (wr_chan), .wr_data (wr_data),
        .dv_in (dv_in), .chan_in (chan_in), .data_in (data_in),
        .dv_out (dv_out), .chan_out (chan_out), .data_out (data_out)
    );

    always #2 clk_in = ~clk_in;

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_chan(input logic [W_CHAN-1:0] expected, input logic [W_CHAN-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: chan_out expected %h actual %h", expected, actual));
        end
    endtask

    task automatic check_data(input logic signed [W_DOUT-1:0] expected,
                              input logic signed [W_DOUT-1:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("** Error: data_out expected %h actual %h", expected, actual));
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk_in) begin
        result_t head;
        if (!reset) begin
            if (dv_out === 1'b1) begin
                if (exp_q.size() == 0) begin
                    abort_run("dv_out went high while no result was expected");
                end else begin
                    head = exp_q.pop_front();
                    check_chan(head.chan, chan_out);
                    check_data(head.data, data_out);
                end
            end else if (dv_out !== 1'b0) begin
                abort_run("dv_out is unknown after reset");
            end
        end
    end

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------
    task automatic tick();
        @(posedge clk_in);
        #1;
        cyc++;
        dv_in = 1'b0;
        wr_en = 1'b0;
    endtask

    task automatic write_cfg(input logic [W_WR_ADDR-1:0] addr, input logic [W_WR_CHAN-1:0] chan,
                             input logic [W_WR_DATA-1:0] data);
        tick();
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_chan = chan;
        wr_data = data;
        apply_cfg_write(addr, chan, data);
    endtask

    function automatic logic signed [W_DIN-1:0] rand_din();
        return W_DIN'($random(seed));
    endfunction

    task automatic configure_random(input int ch);
        write_cfg(PID_SETPOINT, W_WR_CHAN'(ch), $random(seed));
        write_cfg(PID_P_COEF, W_WR_CHAN'(ch), $random(seed));
        write_cfg(PID_I_COEF, W_WR_CHAN'(ch), $random(seed));
        write_cfg(PID_D_COEF, W_WR_CHAN'(ch), $random(seed));
    endtask

    // Expected value fixed at the moment the sample is driven
    task automatic send_sample(input int ch, input logic signed [W_DIN-1:0] din);
        result_t exp;
        tick();
        dv_in          = 1'b1;
        chan_in        = W_CHAN'(ch);
        data_in        = din;
        last_issue[ch] = cyc;
        exp.chan       = W_CHAN'(ch);
        exp.data       = W_DOUT'(predict_output(ch, longint'(din)));
        exp_q.push_back(exp);
    endtask

    // Random channel not seen in the last 6 cycles
    function automatic int pick_free_chan();
        int ch;
        ch = $unsigned($random(seed)) % N_CHAN;
        while ((cyc + 1 - last_issue[ch]) < 6) begin
            ch = (ch + 1) % N_CHAN;
        end
        return ch;
    endfunction

    task automatic run_channel(input int ch, input int n, input bit random_data,
                               input logic signed [W_DIN-1:0] fixed_din);
        int gap;
        for (int k = 0; k < n; k++) begin
            gap = 6 + ($unsigned($random(seed)) % 4);
            while ((cyc + 1 - last_issue[ch]) < gap) begin
                tick();
            end
            send_sample(ch, random_data ? rand_din() : fixed_din);
        end
    endtask

    task automatic wait_drain(output bit drained);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            tick();
            n++;
        end
        drained = (exp_q.size() == 0);
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        bit drained;
        clk_in  = 1'b0;
        reset   = 1'b1;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_chan = '0;
        wr_data = '0;
        dv_in   = 1'b0;
        chan_in = '0;
        data_in = '0;
        zero_all_state();
        for (int i = 0; i < N_CHAN; i++) begin
            last_issue[i] = -100;
        end
        if (pid_delta_width(W_DIN, W_COEF) > 60 || pid_kcoef_width(W_COEF) + W_DIN > 60
            || W_DOUT > 62) begin
            abort_run("Datapath too wide for the 64-bit reference model");
        end
        repeat (2) @(posedge clk_in);
        #1 reset = 1'b0;

        // Idle after reset, then one sample per channel
        repeat (10) tick();
        for (int ch = 0; ch < N_CHAN; ch++) begin
            configure_random(ch);
        end
        for (int ch = 0; ch < N_CHAN; ch++) begin
            send_sample(ch, rand_din());
        end

        // Lone channel with spaced samples
        configure_random(3);
        run_channel(3, N_SINGLE, 1'b1, '0);

        // Back-to-back interleaved channels
        for (int k = 0; k < N_MIX; k++) begin
            send_sample(pick_free_chan(), rand_din());
        end

        // Inverted error
        configure_random(5);
        write_cfg(PID_INV_ERROR, 5, 1);
        run_channel(5, N_INV, 1'b1, '0);

        // Full-scale error with large gains, up then down
        write_cfg(PID_SETPOINT, 2, (1 << (W_DIN - 1)) - 1);
        write_cfg(PID_P_COEF, 2, (1 << (W_COEF - 1)) - 1);
        write_cfg(PID_I_COEF, 2, (1 << (W_COEF - 1)) - 1);
        write_cfg(PID_D_COEF, 2, (1 << (W_COEF - 1)) - 1);
        run_channel(2, N_SAT_UP, 1'b0, {1'b1, {(W_DIN - 1){1'b0}}});
        if (hist_out[2] != DOUT_MAX) begin
            abort_run("Upward run never reached the output maximum");
        end
        write_cfg(PID_SETPOINT, 2, 1 << (W_DIN - 1));
        run_channel(2, N_SAT_DN, 1'b0, {1'b0, {(W_DIN - 1){1'b1}}});
        if (hist_out[2] != DOUT_MIN) begin
            abort_run("Downward run never reached the output minimum");
        end

        // Clear on an idle channel, then ignored writes
        wait_drain(drained);
        if (!drained) begin
            abort_run("Results still missing before the clear request");
        end
        write_cfg(PID_CLR_RQST, 1, 1);
        tick();
        repeat (4) begin
            write_cfg(W_WR_ADDR'($unsigned($random(seed)) % 6),
                      W_WR_CHAN'(N_CHAN + ($unsigned($random(seed)) % (256 - N_CHAN))),
                      $random(seed));
        end
        write_cfg(4'hc, 0, $random(seed));
        for (int k = 0; k < N_CLR; k++) begin
            send_sample(pick_free_chan(), rand_din());
        end

        wait_drain(drained);
        if (!drained) begin
            $display("Expected result for channel %0d never arrived", exp_q[0].chan);
            $display("Test FAILED");
            $fatal(1);
        end else begin
            $display("Test OK");
            $finish;
        end
    end

    // Watchdog sized from the sample count
    initial begin
        repeat ((N_SAMPLES + 200) * 10) @(posedge clk_in);
        $display("Watchdog expired before the test sequence finished");
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

/* vlog.f */
+incdir+verification
verilog/pid_pkg.sv
verilog/pid_param_if.sv
verilog/pid_coef_bank.sv
verilog/pid_filter.sv
verilog/pid_ctrl_top.sv
verification/pid_tb.sv
